/* verilog/exe_pkg.sv */
`default_nettype none

package exe_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	// next sequential instruction
	localparam logic [xlen-1:0] pc_step = 4;

	// synchronous cause codes
	localparam logic [xlen-2:0] cause_i_misaligned = 'd0;
	localparam logic [xlen-2:0] cause_illegal = 'd2;
	localparam logic [xlen-2:0] cause_breakpoint = 'd3;
	localparam logic [xlen-2:0] cause_u_call = 'd8;
	localparam logic [xlen-2:0] cause_s_call = 'd9;
	localparam logic [xlen-2:0] cause_m_call = 'd11;

	// interrupt cause codes, top cause bit set on top of these
	localparam logic [xlen-2:0] cause_u_timer = 'd4;
	localparam logic [xlen-2:0] cause_s_timer = 'd5;
	localparam logic [xlen-2:0] cause_m_timer = 'd7;
	localparam logic [xlen-2:0] cause_u_ext = 'd8;
	localparam logic [xlen-2:0] cause_s_ext = 'd9;
	localparam logic [xlen-2:0] cause_m_ext = 'd11;

	typedef enum logic [1:0] {
		priv_user = 2'd0,
		priv_super = 2'd1,
		priv_machine = 2'd3
	} priv_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	typedef enum logic [1:0] {
		br_none,
		br_cond,
		br_jal,
		br_jalr
	} branch_e;

	typedef enum logic [2:0] {
		cond_eq,
		cond_ne,
		cond_lt,
		cond_ge,
		cond_ltu,
		cond_geu
	} cond_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_link,
		wb_lui,
		wb_auipc
	} wb_sel_e;

	// flags raised by decode
	typedef struct packed {
		logic i_misaligned;
		logic illegal;
		logic ecall;
		logic ebreak;
	} exc_flags_t;

	typedef struct packed {
		logic m_timer;
		logic s_timer;
		logic u_timer;
		logic external;
		logic m_tie;
		logic s_tie;
		logic u_tie;
		logic m_eie;
		logic s_eie;
		logic u_eie;
	} irq_t;

	typedef struct packed {
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;
		logic [xlen-1:0] pc;
		// B, J or I offset
		logic [xlen-1:0] imm;
		logic [xlen-1:0] u_imm;
		logic [reg_addr_w-1:0] rd;
		logic we;
		alu_op_e alu_op;
		branch_e branch;
		cond_e cond;
		wb_sel_e wb_sel;
		exc_flags_t exc;
	} exe_req_t;

	typedef struct packed {
		logic [xlen-1:0] wb_data;
		logic [reg_addr_w-1:0] rd;
		logic we;
		logic [xlen-1:0] pc;
		logic trap;
		logic [xlen-1:0] cause;
		logic redirect;
		logic [xlen-1:0] target;
	} exe_resp_t;

endpackage

`default_nettype wire

/* verilog/exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
	input logic [exe_pkg::xlen-1:0] op_a,
	input logic [exe_pkg::xlen-1:0] op_b,
	input exe_pkg::alu_op_e alu_op,
	input exe_pkg::cond_e cond,
	output logic [exe_pkg::xlen-1:0] result,
	output logic cond_true
);

	logic [4:0] shamt;
	logic lt;
	logic ltu;
	logic eq;

	assign shamt = op_b[4:0];
	assign lt = $signed(op_a) < $signed(op_b);
	assign ltu = op_a < op_b;
	assign eq = op_a == op_b;

	always_comb
	begin
		unique case (alu_op)
			exe_pkg::alu_add: result = op_a + op_b;
			exe_pkg::alu_sub: result = op_a - op_b;
			exe_pkg::alu_sll: result = op_a << shamt;
			exe_pkg::alu_slt: result = {{(exe_pkg::xlen-1){1'b0}}, lt};
			exe_pkg::alu_sltu: result = {{(exe_pkg::xlen-1){1'b0}}, ltu};
			exe_pkg::alu_xor: result = op_a ^ op_b;
			exe_pkg::alu_srl: result = op_a >> shamt;
			exe_pkg::alu_sra: result = $signed(op_a) >>> shamt;
			exe_pkg::alu_or: result = op_a | op_b;
			exe_pkg::alu_and: result = op_a & op_b;
			default: result = '0;
		endcase
	end

	// branch compare on the same operands
	always_comb
	begin
		unique case (cond)
			exe_pkg::cond_eq: cond_true = eq;
			exe_pkg::cond_ne: cond_true = !eq;
			exe_pkg::cond_lt: cond_true = lt;
			exe_pkg::cond_ge: cond_true = !lt;
			exe_pkg::cond_ltu: cond_true = ltu;
			exe_pkg::cond_geu: cond_true = !ltu;
			default: cond_true = 1'b0;
		endcase
	end

	// decode should never hand over an opcode outside the ten defined ones
	always_comb
	begin
		assert final ($isunknown(alu_op) || alu_op inside {exe_pkg::alu_add,
			exe_pkg::alu_sub, exe_pkg::alu_sll, exe_pkg::alu_slt,
			exe_pkg::alu_sltu, exe_pkg::alu_xor, exe_pkg::alu_srl,
			exe_pkg::alu_sra, exe_pkg::alu_or, exe_pkg::alu_and})
		else
			$error("undefined alu_op %0d", alu_op);
	end

endmodule

`default_nettype wire

/* verilog/exe_branch.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_branch (
	input logic [exe_pkg::xlen-1:0] pc,
	input logic [exe_pkg::xlen-1:0] op_a,
	input logic [exe_pkg::xlen-1:0] imm,
	input exe_pkg::branch_e branch,
	input logic cond_true,
	output logic redirect,
	output logic [exe_pkg::xlen-1:0] target
);

	logic [exe_pkg::xlen-1:0] pc_rel;
	logic [exe_pkg::xlen-1:0] reg_rel;

	assign pc_rel = pc + imm;
	// jalr drops the low bit of the sum
	assign reg_rel = (op_a + imm) & ~exe_pkg::xlen'(1);

	assign target = (branch == exe_pkg::br_jalr) ? reg_rel : pc_rel;

	always_comb
	begin
		unique case (branch)
			exe_pkg::br_cond: redirect = cond_true;
			exe_pkg::br_jal: redirect = 1'b1;
			exe_pkg::br_jalr: redirect = 1'b1;
			default: redirect = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/exe_trap.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_trap (
	input exe_pkg::priv_e mode,
	input exe_pkg::irq_t irq,
	input exe_pkg::exc_flags_t exc,
	input logic active,
	output logic trap,
	output logic [exe_pkg::xlen-1:0] cause
);

	logic below_m;
	logic in_user;
	logic m_timer_q;
	logic s_timer_q;
	logic u_timer_q;
	logic m_ext_q;
	logic s_ext_q;
	logic u_ext_q;
	logic hit;
	logic intr;
	logic [exe_pkg::xlen-2:0] code;

	assign below_m = mode != exe_pkg::priv_machine;
	assign in_user = mode == exe_pkg::priv_user;

	// machine needs the enable only, lower levels also need the mode
	assign m_timer_q = irq.m_timer && irq.m_tie;
	assign s_timer_q = irq.s_timer && irq.s_tie && below_m;
	assign u_timer_q = irq.u_timer && irq.u_tie && in_user;
	assign m_ext_q = irq.external && irq.m_eie;
	assign s_ext_q = irq.external && irq.s_eie && below_m;
	assign u_ext_q = irq.external && irq.u_eie && in_user;

	always_comb
	begin
		hit = 1'b1;
		intr = 1'b1;
		code = '0;
		if (m_ext_q)
			code = exe_pkg::cause_m_ext;
		else if (s_ext_q)
			code = exe_pkg::cause_s_ext;
		else if (m_timer_q)
			code = exe_pkg::cause_m_timer;
		else if (s_timer_q)
			code = exe_pkg::cause_s_timer;
		else if (u_ext_q)
			code = exe_pkg::cause_u_ext;
		else if (u_timer_q)
			code = exe_pkg::cause_u_timer;
		else
		begin
			// synchronous causes from here on
			intr = 1'b0;
			if (exc.i_misaligned)
				code = exe_pkg::cause_i_misaligned;
			else if (exc.illegal)
				code = exe_pkg::cause_illegal;
			else if (exc.ecall)
			begin
				unique case (mode)
					exe_pkg::priv_user: code = exe_pkg::cause_u_call;
					exe_pkg::priv_super: code = exe_pkg::cause_s_call;
					default: code = exe_pkg::cause_m_call;
				endcase
			end
			else if (exc.ebreak)
				code = exe_pkg::cause_breakpoint;
			else
				hit = 1'b0;
		end
	end

	assign trap = active && hit;
	assign cause = trap ? {intr, code} : '0;

	// any trap needs a raised flag or some enabled pending line
	always_comb
	begin
		assert final (!trap || (active && ((|exc) ||
			(irq.external && (irq.m_eie || irq.s_eie || irq.u_eie)) ||
			(irq.m_timer && irq.m_tie) || (irq.s_timer && irq.s_tie) ||
			(irq.u_timer && irq.u_tie))))
		else
			$error("trap raised with nothing pending");
	end

endmodule

`default_nettype wire

/* verilog/exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
	input logic clk,
	input logic nrst,
	input logic in_valid,
	output logic in_ready,
	input exe_pkg::exe_req_t in_req,
	output logic out_valid,
	input logic out_ready,
	output exe_pkg::exe_resp_t out_resp,
	input exe_pkg::priv_e mode,
	input exe_pkg::irq_t irq
);

	// contents of the second register stage
	typedef struct packed {
		logic [exe_pkg::xlen-1:0] alu_res;
		logic [exe_pkg::xlen-1:0] auipc_sum;
		logic [exe_pkg::xlen-1:0] u_imm;
		logic [exe_pkg::xlen-1:0] pc;
		logic [exe_pkg::reg_addr_w-1:0] rd;
		logic we;
		exe_pkg::wb_sel_e wb_sel;
		logic redirect;
		logic [exe_pkg::xlen-1:0] target;
		exe_pkg::exc_flags_t exc;
	} s6_t;

	exe_pkg::exe_req_t s5_req;
	logic s5_valid;
	logic s5_adv;

	s6_t s6;
	s6_t s6_d;
	logic s6_valid;
	logic s6_adv;

	logic [exe_pkg::xlen-1:0] alu_res;
	logic cond_true;
	logic redirect;
	logic [exe_pkg::xlen-1:0] target;
	logic [exe_pkg::xlen-1:0] wb_data;
	logic trap;
	logic [exe_pkg::xlen-1:0] cause;

	assign s6_adv = !s6_valid || out_ready;
	assign s5_adv = !s5_valid || s6_adv;
	// hold off intake while a trap waits, the item behind it is dropped
	assign in_ready = s5_adv && !trap;

	exe_alu u_alu (
		.op_a(s5_req.op_a),
		.op_b(s5_req.op_b),
		.alu_op(s5_req.alu_op),
		.cond(s5_req.cond),
		.result(alu_res),
		.cond_true(cond_true)
	);

	exe_branch u_branch (
		.pc(s5_req.pc),
		.op_a(s5_req.op_a),
		.imm(s5_req.imm),
		.branch(s5_req.branch),
		.cond_true(cond_true),
		.redirect(redirect),
		.target(target)
	);

	always_comb
	begin
		s6_d.alu_res = alu_res;
		s6_d.auipc_sum = s5_req.pc + s5_req.u_imm;
		s6_d.u_imm = s5_req.u_imm;
		s6_d.pc = s5_req.pc;
		s6_d.rd = s5_req.rd;
		s6_d.we = s5_req.we;
		s6_d.wb_sel = s5_req.wb_sel;
		s6_d.redirect = redirect;
		s6_d.target = target;
		s6_d.exc = s5_req.exc;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			s5_valid <= 1'b0;
			s6_valid <= 1'b0;
		end
		else
		begin
			if (s5_adv)
				s5_valid <= in_valid && in_ready;
			// a departing trap flushes the younger item
			if (s6_adv)
				s6_valid <= s5_valid && !trap;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			s5_req <= in_req;
		if (s6_adv && s5_valid)
			s6 <= s6_d;
	end

	exe_trap u_trap (
		.mode(mode),
		.irq(irq),
		.exc(s6.exc),
		.active(s6_valid),
		.trap(trap),
		.cause(cause)
	);

	always_comb
	begin
		unique case (s6.wb_sel)
			exe_pkg::wb_alu: wb_data = s6.alu_res;
			exe_pkg::wb_link: wb_data = s6.pc + exe_pkg::pc_step;
			exe_pkg::wb_lui: wb_data = s6.u_imm;
			exe_pkg::wb_auipc: wb_data = s6.auipc_sum;
		endcase
	end

	assign out_valid = s6_valid;

	always_comb
	begin
		out_resp.wb_data = wb_data;
		out_resp.rd = s6.rd;
		out_resp.we = s6.we && !trap;
		out_resp.pc = s6.pc;
		out_resp.trap = trap;
		out_resp.cause = cause;
		out_resp.redirect = s6.redirect;
		out_resp.target = s6.target;
	end

	// stalled response must not move
	assert property (@(posedge clk) disable iff (!nrst)
		out_valid && !out_ready |=> $stable(out_resp))
	else
		$error("out_resp changed while stalled");

	assert property (@(posedge clk) disable iff (!nrst)
		out_valid && out_resp.trap |-> !out_resp.we)
	else
		$error("trapping response still writes rd");

endmodule

`default_nettype wire

/* tb/tb_exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exe_stage;

	localparam int wait_limit = 100;
	localparam int n_alu_each = 8;
	localparam int n_bp = 200;
	// alu, write-back, control, sync traps, interrupts, back-pressure
	localparam int total_reqs = 10 * n_alu_each + 12 + 32 + 48 + 3 * 1024 + 3 + n_bp;
	localparam longint watchdog_ns = (longint'(total_reqs) * 40 + 2000) * 20;

	logic clk;
	logic nrst;
	logic in_valid;
	logic in_ready;
	exe_pkg::exe_req_t in_req;
	logic out_valid;
	logic out_ready;
	exe_pkg::exe_resp_t out_resp;
	exe_pkg::priv_e mode;
	exe_pkg::irq_t irq;

	logic [31:0] rng_state;
	int errors;
	int tests_passed;
	int tests_failed;
	exe_pkg::exe_resp_t pending[$];

	exe_stage dut (
		.clk(clk),
		.nrst(nrst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_req(in_req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_resp(out_resp),
		.mode(mode),
		.irq(irq)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired before the tests completed");
		$display("Regression failed");
		$finish;
	end

	// xorshift32
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic exe_pkg::priv_e pick_mode(input int i);
		case (i)
			0: return exe_pkg::priv_user;
			1: return exe_pkg::priv_super;
			default: return exe_pkg::priv_machine;
		endcase
	endfunction

	function automatic exe_pkg::exe_resp_t expected_resp(input exe_pkg::exe_req_t r,
		input exe_pkg::priv_e m, input exe_pkg::irq_t q);
		exe_pkg::exe_resp_t e;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] sh;
		logic [31:0] res;
		logic [31:0] flip;
		logic [31:0] c;
		logic taken;
		logic lower_ok;
		logic user_ok;
		logic m_tmr;
		logic s_tmr;
		logic u_tmr;
		logic m_ext;
		logic s_ext;
		logic u_ext;
		a = r.op_a;
		b = r.op_b;
		sh = b[4:0];
		// signed compare by offsetting both operands
		flip = 32'h8000_0000;
		case (r.alu_op)
			exe_pkg::alu_add: res = a + b;
			exe_pkg::alu_sub: res = a - b;
			exe_pkg::alu_sll: res = a << sh;
			exe_pkg::alu_slt: res = ((a ^ flip) < (b ^ flip)) ? 32'd1 : 32'd0;
			exe_pkg::alu_sltu: res = (a < b) ? 32'd1 : 32'd0;
			exe_pkg::alu_xor: res = a ^ b;
			exe_pkg::alu_srl: res = a >> sh;
			exe_pkg::alu_sra: res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
			exe_pkg::alu_or: res = a | b;
			default: res = a & b;
		endcase
		case (r.cond)
			exe_pkg::cond_eq: taken = a == b;
			exe_pkg::cond_ne: taken = a != b;
			exe_pkg::cond_lt: taken = (a ^ flip) < (b ^ flip);
			exe_pkg::cond_ge: taken = (a ^ flip) >= (b ^ flip);
			exe_pkg::cond_ltu: taken = a < b;
			default: taken = a >= b;
		endcase
		e = '0;
		e.rd = r.rd;
		e.pc = r.pc;
		case (r.wb_sel)
			exe_pkg::wb_alu: e.wb_data = res;
			exe_pkg::wb_link: e.wb_data = r.pc + 32'd4;
			exe_pkg::wb_lui: e.wb_data = r.u_imm;
			default: e.wb_data = r.pc + r.u_imm;
		endcase
		if (r.branch == exe_pkg::br_cond)
			e.redirect = taken;
		else
			e.redirect = r.branch == exe_pkg::br_jal || r.branch == exe_pkg::br_jalr;
		if (r.branch == exe_pkg::br_jalr)
			e.target = (a + r.imm) & 32'hffff_fffe;
		else
			e.target = r.pc + r.imm;
		lower_ok = m != exe_pkg::priv_machine;
		user_ok = m == exe_pkg::priv_user;
		m_tmr = q.m_timer && q.m_tie;
		s_tmr = q.s_timer && q.s_tie && lower_ok;
		u_tmr = q.u_timer && q.u_tie && user_ok;
		m_ext = q.external && q.m_eie;
		s_ext = q.external && q.s_eie && lower_ok;
		u_ext = q.external && q.u_eie && user_ok;
		// lowest priority first, each higher cause overwrites
		c = '0;
		if (r.exc.ebreak)
			c = {1'b0, exe_pkg::cause_breakpoint};
		if (r.exc.ecall)
			c = {1'b0, user_ok ? exe_pkg::cause_u_call :
				lower_ok ? exe_pkg::cause_s_call : exe_pkg::cause_m_call};
		if (r.exc.illegal)
			c = {1'b0, exe_pkg::cause_illegal};
		if (r.exc.i_misaligned)
			c = {1'b0, exe_pkg::cause_i_misaligned};
		if (u_tmr)
			c = {1'b1, exe_pkg::cause_u_timer};
		if (u_ext)
			c = {1'b1, exe_pkg::cause_u_ext};
		if (s_tmr)
			c = {1'b1, exe_pkg::cause_s_timer};
		if (m_tmr)
			c = {1'b1, exe_pkg::cause_m_timer};
		if (s_ext)
			c = {1'b1, exe_pkg::cause_s_ext};
		if (m_ext)
			c = {1'b1, exe_pkg::cause_m_ext};
		e.trap = (|r.exc) || m_tmr || s_tmr || u_tmr || m_ext || s_ext || u_ext;
		e.cause = e.trap ? c : '0;
		e.we = r.we && !e.trap;
		return e;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic compare_resp(input exe_pkg::exe_resp_t got, input exe_pkg::exe_resp_t exp,
		input string what);
		check_value(32'(got.trap), 32'(exp.trap), {what, " trap"});
		if (exp.trap)
			check_value(got.cause, exp.cause, {what, " cause"});
		check_value(32'(got.we), 32'(exp.we), {what, " we"});
		check_value(32'(got.rd), 32'(exp.rd), {what, " rd"});
		check_value(got.pc, exp.pc, {what, " pc"});
		if (!exp.trap)
			check_value(got.wb_data, exp.wb_data, {what, " wb_data"});
		check_value(32'(got.redirect), 32'(exp.redirect), {what, " redirect"});
		if (exp.redirect)
			check_value(got.target, exp.target, {what, " target"});
	endtask

	task automatic compare_held(input exe_pkg::exe_resp_t got, input exe_pkg::exe_resp_t held);
		check_value(got.wb_data, held.wb_data, "stalled wb_data");
		check_value(got.pc, held.pc, "stalled pc");
		check_value(got.cause, held.cause, "stalled cause");
		check_value(got.target, held.target, "stalled target");
		check_value(32'({got.rd, got.we, got.trap, got.redirect}),
			32'({held.rd, held.we, held.trap, held.redirect}), "stalled flags");
	endtask

	// entered and left 1 ns after a rising edge
	task automatic send(input exe_pkg::exe_req_t r);
		int waited;
		waited = 0;
		in_req = r;
		in_valid = 1'b1;
		@(negedge clk);
		while (!in_ready && waited < wait_limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (!in_ready)
		begin
			$display("timeout: request was not accepted by the DUT");
			errors++;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic receive(output exe_pkg::exe_resp_t resp, output bit arrived);
		int waited;
		waited = 0;
		out_ready = 1'b1;
		@(negedge clk);
		while (!out_valid && waited < wait_limit)
		begin
			@(negedge clk);
			waited++;
		end
		arrived = out_valid;
		resp = out_resp;
		if (!arrived)
		begin
			$display("timeout: expected response never arrived");
			errors++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic issue_and_check(input exe_pkg::exe_req_t r, input string what);
		exe_pkg::exe_resp_t resp;
		bit arrived;
		send(r);
		receive(resp, arrived);
		if (arrived)
			compare_resp(resp, expected_resp(r, mode, irq), what);
	endtask

	function automatic exe_pkg::exe_req_t plain_req();
		exe_pkg::exe_req_t r;
		logic [31:0] t;
		r = '0;
		r.op_a = next_random();
		r.op_b = next_random();
		r.pc = next_random() & 32'hffff_fffc;
		t = next_random();
		r.imm = {{20{t[11]}}, t[11:1], 1'b0};
		r.u_imm = next_random() & 32'hffff_f000;
		r.rd = 5'(next_random());
		r.we = 1'b1;
		r.alu_op = exe_pkg::alu_add;
		r.branch = exe_pkg::br_none;
		r.cond = exe_pkg::cond_eq;
		r.wb_sel = exe_pkg::wb_alu;
		return r;
	endfunction

	function automatic exe_pkg::exe_req_t random_req();
		exe_pkg::exe_req_t r;
		r = plain_req();
		r.alu_op = exe_pkg::alu_op_e'(4'(next_random() % 10));
		r.wb_sel = exe_pkg::wb_sel_e'(2'(next_random()));
		r.branch = exe_pkg::branch_e'(2'(next_random()));
		r.cond = exe_pkg::cond_e'(3'(next_random() % 6));
		return r;
	endfunction

	task automatic report_test(input string name, input int start);
		if (errors == start)
		begin
			$display("test %s: ok", name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: FAILED with %0d errors", name, errors - start);
			tests_failed++;
		end
	endtask

	task automatic test_alu_results();
		exe_pkg::exe_req_t r;
		int start;
		start = errors;
		for (int op = 0; op < 10; op++)
		begin
			for (int k = 0; k < n_alu_each; k++)
			begin
				r = plain_req();
				r.alu_op = exe_pkg::alu_op_e'(4'(op));
				// corner operands for shifts and compares
				if (k == 0)
				begin
					r.op_a = 32'h8000_0000;
					r.op_b = 32'h0000_001f;
				end
				if (k == 1)
					r.op_b = r.op_a;
				issue_and_check(r, $sformatf("alu op %0d", op));
			end
		end
		report_test("alu_results", start);
	endtask

	task automatic test_wb_sources();
		exe_pkg::exe_req_t r;
		int start;
		start = errors;
		for (int k = 0; k < 4; k++)
		begin
			for (int s = 1; s < 4; s++)
			begin
				r = plain_req();
				r.wb_sel = exe_pkg::wb_sel_e'(2'(s));
				issue_and_check(r, $sformatf("wb_sel %0d", s));
			end
		end
		report_test("wb_sources", start);
	endtask

	task automatic test_control_transfer();
		exe_pkg::exe_req_t r;
		logic [31:0] pair_a [4];
		logic [31:0] pair_b [4];
		int start;
		start = errors;
		pair_a = '{32'd5, 32'd3, 32'hffff_ffff, 32'd1};
		pair_b = '{32'd5, 32'd9, 32'd1, 32'hffff_ffff};
		for (int c = 0; c < 6; c++)
		begin
			for (int p = 0; p < 4; p++)
			begin
				r = plain_req();
				r.branch = exe_pkg::br_cond;
				r.cond = exe_pkg::cond_e'(3'(c));
				r.op_a = pair_a[p];
				r.op_b = pair_b[p];
				r.we = 1'b0;
				issue_and_check(r, $sformatf("cond %0d pair %0d", c, p));
			end
		end
		for (int k = 0; k < 8; k++)
		begin
			r = plain_req();
			r.branch = (k < 4) ? exe_pkg::br_jal : exe_pkg::br_jalr;
			r.wb_sel = exe_pkg::wb_link;
			// odd sum so that jalr must clear bit 0
			r.op_a = next_random() | 32'd1;
			issue_and_check(r, (k < 4) ? "jal" : "jalr");
		end
		report_test("control_transfer", start);
	endtask

	task automatic test_sync_traps();
		exe_pkg::exe_req_t r;
		exe_pkg::exe_req_t younger;
		exe_pkg::exe_resp_t resp;
		bit arrived;
		int start;
		start = errors;
		for (int mi = 0; mi < 3; mi++)
		begin
			mode = pick_mode(mi);
			for (int f = 1; f < 16; f++)
			begin
				r = plain_req();
				r.exc = exe_pkg::exc_flags_t'(4'(f));
				issue_and_check(r, $sformatf("mode %0d flags %0d", mi, f));
			end
		end
		mode = exe_pkg::priv_machine;
		// younger item right behind a trap gets flushed
		r = plain_req();
		r.exc.illegal = 1'b1;
		younger = plain_req();
		send(r);
		send(younger);
		receive(resp, arrived);
		if (arrived)
			compare_resp(resp, expected_resp(r, mode, irq), "flushing trap");
		repeat (6)
		begin
			@(negedge clk);
			check_value(32'(out_valid), 32'd0, "flushed item reached the output");
		end
		@(posedge clk);
		#1;
		issue_and_check(plain_req(), "after flush");
		report_test("sync_traps", start);
	endtask

	task automatic test_interrupts();
		exe_pkg::exe_req_t r;
		int start;
		start = errors;
		for (int mi = 0; mi < 3; mi++)
		begin
			mode = pick_mode(mi);
			for (int bits = 0; bits < 1024; bits++)
			begin
				irq = exe_pkg::irq_t'(10'(bits));
				issue_and_check(plain_req(), $sformatf("mode %0d irq %h", mi, bits));
			end
		end
		// pending machine timer against exception flags
		irq = '0;
		irq.m_timer = 1'b1;
		irq.m_tie = 1'b1;
		for (int mi = 0; mi < 3; mi++)
		begin
			mode = pick_mode(mi);
			r = plain_req();
			r.exc.illegal = 1'b1;
			r.exc.ecall = 1'b1;
			issue_and_check(r, "interrupt over exception");
		end
		irq = '0;
		mode = exe_pkg::priv_machine;
		report_test("interrupts", start);
	endtask

	task automatic drain_with_stalls(input int count);
		exe_pkg::exe_resp_t held;
		exe_pkg::exe_resp_t exp;
		bit stalled;
		int received;
		int idle;
		stalled = 1'b0;
		received = 0;
		idle = 0;
		while (received < count && idle < wait_limit)
		begin
			out_ready = (next_random() % 8) < 5;
			@(negedge clk);
			if (out_valid)
			begin
				idle = 0;
				if (stalled)
					compare_held(out_resp, held);
				if (out_ready)
				begin
					exp = pending.pop_front();
					compare_resp(out_resp, exp, $sformatf("stream item %0d", received));
					received++;
					stalled = 1'b0;
				end
				else
				begin
					held = out_resp;
					stalled = 1'b1;
				end
			end
			else
				idle++;
			@(posedge clk);
			#1;
		end
		if (received < count)
		begin
			$display("timeout: only %0d of %0d streamed responses arrived", received, count);
			errors++;
		end
		out_ready = 1'b1;
	endtask

	task automatic test_backpressure();
		exe_pkg::exe_req_t r;
		int start;
		start = errors;
		pending.delete();
		fork
			begin
				for (int i = 0; i < n_bp; i++)
				begin
					r = random_req();
					pending.push_back(expected_resp(r, mode, irq));
					send(r);
				end
			end
			drain_with_stalls(n_bp);
		join
		report_test("backpressure", start);
	endtask

	initial
	begin
		rng_state = 32'd72235;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		nrst = 1'b0;
		in_valid = 1'b0;
		in_req = '0;
		out_ready = 1'b1;
		mode = exe_pkg::priv_machine;
		irq = '0;
		repeat (16) @(posedge clk);
		#1;
		nrst = 1'b1;
		@(negedge clk);
		check_value(32'(in_ready), 32'd1, "in_ready after reset");
		check_value(32'(out_valid), 32'd0, "out_valid after reset");
		@(posedge clk);
		#1;
		test_alu_results();
		test_wb_sources();
		test_control_transfer();
		test_sync_traps();
		test_interrupts();
		test_backpressure();
		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* exe_stage.f */
verilog/exe_pkg.sv
verilog/exe_alu.sv
verilog/exe_branch.sv
verilog/exe_trap.sv
verilog/exe_stage.sv
tb/tb_exe_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_exe_stage
FILELIST ?= exe_stage.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAIL_MSG ?= Regression failed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
